// ==== build.f ====
+incdir+verilog
verilog/diad_isa_pkg.sv
verilog/diad_pipe_pkg.sv
verilog/diad_mem.sv
verilog/diad_fetch.sv
verilog/diad_decode.sv
verilog/diad_execute.sv
verilog/diad_memory.sv
verilog/diad.sv
verif/diad_checker.sv
verif/diad_monitor.sv
verif/diad_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the diad testbench with Verilator, runs it and checks the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module diad_tb -f build.f -o diad_sim \
    || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/diad_sim +verilator+error+limit+100)"
echo "$sim_out"
grep -qx "No errors" <<< "$sim_out" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/diad_checker.sv ====
`timescale 1ns/10ps

module diad_checker (
    input logic                   iw_clk,
    input logic                   iw_rst,
    input logic                   run,
    input logic                   load_ready,
    input logic                   retire_valid,
    input logic                   retire_ready,
    input diad_pipe_pkg::retire_t retire
);

    int assert_fails = 0;

    a_reset_idle: assert property (@(posedge iw_clk) iw_rst |-> !retire_valid)
        else begin
            assert_fails++;
            $error("retire_valid is high during reset");
        end

    a_retire_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
        else begin
            assert_fails++;
            $error("retire record changed while the transfer was held off");
        end

    a_load_closed: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (run || retire_valid) |-> !load_ready)
        else begin
            assert_fails++;
            $error("load_ready is high while run is high or a record is pending");
        end

    a_no_r0_write: assert property (@(posedge iw_clk) disable iff (iw_rst)
        retire_valid |-> !(retire.we && (retire.rd == '0)))
        else begin
            assert_fails++;
            $error("retire record writes r0");
        end

endmodule

bind diad diad_checker u_checker (
    .iw_clk      (iw_clk),
    .iw_rst      (iw_rst),
    .run         (run),
    .load_ready  (load_ready),
    .retire_valid(retire_valid),
    .retire_ready(retire_ready),
    .retire      (retire)
);

// ==== verif/diad_monitor.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_monitor (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  logic                   load_valid,
    input  logic                   load_ready,
    input  diad_pipe_pkg::addr_t   load_addr,
    input  diad_pipe_pkg::word_t   load_data,
    input  logic                   retire_valid,
    input  logic                   retire_ready,
    input  diad_pipe_pkg::retire_t retire,
    output int                     errors,
    output int                     retired
);

    localparam int MEM_WORDS = 1 << `DIAD_ADDR_W;

    diad_pipe_pkg::word_t model_mem [MEM_WORDS];
    diad_pipe_pkg::word_t model_reg [`DIAD_NREG];
    diad_pipe_pkg::addr_t exp_pc;

    // Executes one instruction on the model state and returns its record.
    function automatic diad_pipe_pkg::retire_t run_model(input diad_pipe_pkg::addr_t pc);
        diad_isa_pkg::instr_u   ins;
        diad_pipe_pkg::retire_t rec;
        diad_pipe_pkg::word_t   a;
        diad_pipe_pkg::word_t   b;
        diad_pipe_pkg::word_t   imm;
        diad_pipe_pkg::addr_t   ea;
        ins = model_mem[pc];
        a   = model_reg[ins.r.rs1];
        b   = model_reg[ins.r.rs2];
        imm = {{9{ins.i.imm[6]}}, ins.i.imm};
        ea  = diad_pipe_pkg::addr_t'(a + imm);
        rec.pc    = pc;
        rec.instr = ins;
        rec.rd    = ins.i.rd;
        rec.we    = (ins.i.opcode != diad_isa_pkg::OP_ST) && (ins.i.rd != '0);
        case (ins.r.opcode)
            diad_isa_pkg::OP_ADD:  rec.value = a + b;
            diad_isa_pkg::OP_SUB:  rec.value = a - b;
            diad_isa_pkg::OP_AND:  rec.value = a & b;
            diad_isa_pkg::OP_OR:   rec.value = a | b;
            diad_isa_pkg::OP_XOR:  rec.value = a ^ b;
            diad_isa_pkg::OP_ADDI: rec.value = a + imm;
            diad_isa_pkg::OP_LD:   rec.value = model_mem[ea];
            default: begin
                rec.value     = model_reg[ins.i.rd];  // Store data register.
                model_mem[ea] = rec.value;
            end
        endcase
        if (rec.we) begin
            model_reg[rec.rd] = rec.value;
        end
        return rec;
    endfunction

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want) begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // Handshakes are taken on the falling edge.
    always @(negedge iw_clk) begin
        diad_pipe_pkg::retire_t want;
        if (iw_rst) begin
            errors  = 0;
            retired = 0;
            exp_pc  = '0;
            for (int r = 0; r < `DIAD_NREG; r++) begin
                model_reg[r] = '0;
            end
        end else begin
            if (load_valid && load_ready) begin
                model_mem[load_addr] = load_data;
            end
            if (retire_valid && retire_ready) begin
                want = run_model(exp_pc);
                check_field("retire.pc", 16'(retire.pc), 16'(want.pc));
                check_field("retire.instr", retire.instr, want.instr);
                check_field("retire.we", 16'(retire.we), 16'(want.we));
                check_field("retire.rd", 16'(retire.rd), 16'(want.rd));
                check_field("retire.value", retire.value, want.value);
                exp_pc = exp_pc + 1'b1;
                retired++;
            end
        end
    end

endmodule

// ==== verif/diad_tb.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_tb;

    localparam int  PROG_LEN        = 120;
    localparam int  MEM_WORDS       = 1 << `DIAD_ADDR_W;
    localparam int  RESET_CYCLES    = 16;
    localparam int  WATCHDOG_CYCLES = RESET_CYCLES + 2 * MEM_WORDS + PROG_LEN * 20;
    localparam time DRIVE_DELAY     = 10;

    logic                   iw_clk;
    logic                   iw_rst;
    logic                   run;
    logic                   load_valid;
    logic                   load_ready;
    diad_pipe_pkg::addr_t   load_addr;
    diad_pipe_pkg::word_t   load_data;
    logic                   retire_valid;
    logic                   retire_ready;
    diad_pipe_pkg::retire_t retire;
    logic [31:0]            lcg_state;
    diad_pipe_pkg::word_t   image [MEM_WORDS];
    int                     mon_errors;
    int                     retired;
    int                     count_err;

    diad dut (.*);

    diad_monitor u_monitor (.*, .errors(mon_errors), .retired(retired));

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic diad_pipe_pkg::word_t enc_r(input diad_isa_pkg::opcode_e op,
                                                   input int rd, input int rs1, input int rs2);
        diad_isa_pkg::rfmt_t f;
        f.opcode = op;
        f.rd     = diad_isa_pkg::reg_t'(rd);
        f.rs1    = diad_isa_pkg::reg_t'(rs1);
        f.rs2    = diad_isa_pkg::reg_t'(rs2);
        f.unused = '0;
        return f;
    endfunction

    function automatic diad_pipe_pkg::word_t enc_i(input diad_isa_pkg::opcode_e op,
                                                   input int rd, input int rs1, input int imm);
        diad_isa_pkg::ifmt_t f;
        f.opcode = op;
        f.rd     = diad_isa_pkg::reg_t'(rd);
        f.rs1    = diad_isa_pkg::reg_t'(rs1);
        f.imm    = 7'(imm);
        return f;
    endfunction

    // r6 and r7 stay data pointers, so random writes only reach r0 to r5.
    function automatic diad_pipe_pkg::word_t random_instr();
        int op;
        int rd;
        int ra;
        int rb;
        op = next_rand() % 8;
        rd = next_rand() % 6;
        ra = next_rand() % 8;
        rb = next_rand() % 8;
        case (op)
            5: return enc_i(diad_isa_pkg::OP_ADDI, rd, ra, int'(next_rand() % 128) - 64);
            6: return enc_i(diad_isa_pkg::OP_LD, rd, 6 + rb % 2, int'(next_rand() % 8) - 4);
            7: return enc_i(diad_isa_pkg::OP_ST, ra, 6 + rb % 2, int'(next_rand() % 8) - 4);
            default: return enc_r(diad_isa_pkg::opcode_e'(op), rd, ra, rb);
        endcase
    endfunction

    function automatic logic random_ready();
        logic [15:0] r;
        r = next_rand();
        return r[1:0] != 2'b00;  // Low about one cycle in four.
    endfunction

    task automatic build_program();
        image[0] = enc_i(diad_isa_pkg::OP_ADDI, 6, 0, -64);  // Data base 0xc0.
        image[1] = enc_i(diad_isa_pkg::OP_ADDI, 7, 6, 4);
        for (int r = 1; r <= 5; r++) begin
            image[r + 1] = enc_i(diad_isa_pkg::OP_ADDI, r, 0, int'(next_rand() % 128) - 64);
        end
        image[7]  = enc_i(diad_isa_pkg::OP_ADDI, 0, 1, 5);
        image[8]  = enc_r(diad_isa_pkg::OP_ADD, 1, 0, 2);
        image[9]  = enc_i(diad_isa_pkg::OP_ST, 3, 6, 0);
        image[10] = enc_i(diad_isa_pkg::OP_LD, 4, 6, 0);    // Reads the store just ahead.
        image[11] = enc_r(diad_isa_pkg::OP_ADD, 5, 4, 4);   // Load-use.
        image[12] = enc_r(diad_isa_pkg::OP_SUB, 2, 5, 1);
        image[13] = enc_r(diad_isa_pkg::OP_XOR, 0, 2, 3);
        image[14] = enc_r(diad_isa_pkg::OP_AND, 3, 2, 5);
        image[15] = enc_r(diad_isa_pkg::OP_OR, 1, 3, 0);
        for (int a = 16; a < PROG_LEN; a++) begin
            image[a] = random_instr();
        end
        for (int a = PROG_LEN; a < MEM_WORDS; a++) begin
            image[a] = next_rand();
        end
    endtask

    task automatic load_program();
        logic taken;
        for (int a = 0; a < MEM_WORDS; a++) begin
            load_valid = 1'b1;
            load_addr  = diad_pipe_pkg::addr_t'(a);
            load_data  = image[a];
            taken      = 1'b0;
            while (!taken) begin
                @(negedge iw_clk);
                taken = load_ready;
                @(posedge iw_clk);
                #DRIVE_DELAY;
            end
        end
        load_valid = 1'b0;
    endtask

    task automatic finish_run(input int tb_errors);
        int total;
        total = mon_errors + tb_errors + dut.u_checker.assert_fails;
        $display("Closing report: %0d monitor errors, %0d testbench errors, %0d assertion failures",
                 mon_errors, tb_errors, dut.u_checker.assert_fails);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        iw_clk = 1'b0;
        forever #50 iw_clk = ~iw_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge iw_clk);
        $display("Watchdog expired after %0d cycles before the program drained",
                 WATCHDOG_CYCLES);
        finish_run(1);
    end

    initial begin
        iw_rst       = 1'b1;
        run          = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        retire_ready = 1'b1;
        count_err    = 0;
        lcg_state    = 32'hb673_9d39;
        build_program();
        repeat (RESET_CYCLES) @(posedge iw_clk);
        #DRIVE_DELAY;
        iw_rst = 1'b0;
        load_program();
        run = 1'b1;
        while (dut.u_fetch.pc != PROG_LEN) begin  // Stop issue after the last word.
            @(posedge iw_clk);
            #DRIVE_DELAY;
            retire_ready = random_ready();
        end
        run = 1'b0;
        do begin
            @(posedge iw_clk);
            #DRIVE_DELAY;
            retire_ready = random_ready();
        end while (!load_ready);
        retire_ready = 1'b1;
        if (retired != PROG_LEN) begin
            $display("Retired %0d instructions instead of %0d", retired, PROG_LEN);
            count_err++;
        end
        finish_run(count_err);
    end

endmodule

// ==== verilog/diad.sv ====
`timescale 1ns/10ps

module diad (
    input  logic                    iw_clk,
    input  logic                    iw_rst,
    input  logic                    run,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  diad_pipe_pkg::addr_t    load_addr,
    input  diad_pipe_pkg::word_t    load_data,
    output logic                    retire_valid,
    input  logic                    retire_ready,
    output diad_pipe_pkg::retire_t  retire
);

    diad_pipe_pkg::addr_t    a_addr;
    diad_pipe_pkg::word_t    a_rdata;
    logic                    b_we;
    diad_pipe_pkg::addr_t    b_addr;
    diad_pipe_pkg::word_t    b_wdata;
    diad_pipe_pkg::word_t    b_rdata;
    logic                    advance;
    logic                    stall;
    logic                    if_valid;
    diad_pipe_pkg::addr_t    if_pc;
    diad_isa_pkg::instr_u    if_instr;
    diad_pipe_pkg::dec_ex_t  dec_ex;
    diad_pipe_pkg::ex_mem_t  ex_mem;
    diad_pipe_pkg::wb_t      wb;

    diad_mem u_mem (
        .iw_clk (iw_clk),
        .a_addr (a_addr),
        .a_rdata(a_rdata),
        .b_we   (b_we),
        .b_addr (b_addr),
        .b_wdata(b_wdata),
        .b_rdata(b_rdata)
    );

    diad_fetch u_fetch (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .run      (run),
        .advance  (advance),
        .stall    (stall),
        .mem_addr (a_addr),
        .mem_rdata(a_rdata),
        .out_valid(if_valid),
        .out_pc   (if_pc),
        .out_instr(if_instr)
    );

    diad_decode u_decode (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .advance (advance),
        .in_valid(if_valid),
        .in_pc   (if_pc),
        .in_instr(if_instr),
        .wb      (wb),
        .stall   (stall),
        .out     (dec_ex)
    );

    diad_execute u_execute (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .advance(advance),
        .in     (dec_ex),
        .out    (ex_mem)
    );

    diad_memory u_memory (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .run         (run),
        .in          (ex_mem),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .b_we        (b_we),
        .b_addr      (b_addr),
        .b_wdata     (b_wdata),
        .b_rdata     (b_rdata),
        .wb          (wb),
        .retire_valid(retire_valid),
        .retire_ready(retire_ready),
        .retire      (retire),
        .advance     (advance)
    );

endmodule

// ==== verilog/diad_config.svh ====
`ifndef DIAD_CONFIG_SVH
`define DIAD_CONFIG_SVH

// Word address bits of the shared memory.
`define DIAD_ADDR_W 8

// Instruction and register width.
`define DIAD_DATA_W 16

// Register count, r0 reads as zero.
`define DIAD_NREG 8

// Cycles from fetch issue to retire_valid without stalls.
`define DIAD_PIPE_DEPTH 6

`endif

// ==== verilog/diad_decode.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_decode (
    input  logic                     iw_clk,
    input  logic                     iw_rst,
    input  logic                     advance,
    input  logic                     in_valid,
    input  diad_pipe_pkg::addr_t     in_pc,
    input  diad_isa_pkg::instr_u     in_instr,
    input  diad_pipe_pkg::wb_t       wb,
    output logic                     stall,
    output diad_pipe_pkg::dec_ex_t   out
);

    diad_pipe_pkg::word_t rf [`DIAD_NREG];
    logic [`DIAD_NREG-1:0] busy;
    logic [`DIAD_NREG-1:0] busy_set;
    logic [`DIAD_NREG-1:0] busy_clr;
    diad_isa_pkg::reg_t   rd;
    diad_isa_pkg::reg_t   rs1;
    diad_isa_pkg::reg_t   rs2;
    logic                 is_rfmt;
    logic                 is_store;
    logic                 writes;
    logic                 issue;
    diad_pipe_pkg::word_t opnd_a;
    diad_pipe_pkg::word_t opnd_b;

    assign is_rfmt  = in_instr.r.opcode <= diad_isa_pkg::OP_XOR;
    assign is_store = in_instr.i.opcode == diad_isa_pkg::OP_ST;

    assign rs1 = in_instr.r.rs1;
    assign rs2 = in_instr.r.rs2;
    assign rd  = in_instr.i.rd;

    assign writes = !is_store && (rd != '0);

    // The rd field is checked for every opcode. For ST it is a source,
    // otherwise waiting on it keeps one writer per busy bit.
    assign stall = in_valid && (busy[rs1] || busy[rd] || (is_rfmt && busy[rs2]));

    assign issue = advance && in_valid && !stall;

    assign opnd_a = rf[rs1];
    assign opnd_b = is_rfmt ? rf[rs2] : rf[rd];

    always_comb begin
        busy_set = '0;
        busy_clr = '0;
        if (issue && writes) begin
            busy_set[rd] = 1'b1;
        end
        if (wb.en) begin
            busy_clr[wb.rd] = 1'b1;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~busy_clr) | busy_set;
        end
    end

    // Architectural registers start at zero, r0 is never written.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `DIAD_NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            rf[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out <= '0;
        end else if (advance) begin
            out <= '{valid: issue,
                     pc:    in_pc,
                     instr: in_instr,
                     a:     opnd_a,
                     b:     opnd_b};  // Bubble while stalled.
        end
    end

endmodule

// ==== verilog/diad_execute.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_execute (
    input  logic                    iw_clk,
    input  logic                    iw_rst,
    input  logic                    advance,
    input  diad_pipe_pkg::dec_ex_t  in,
    output diad_pipe_pkg::ex_mem_t  out
);

    diad_pipe_pkg::word_t imm_ext;
    diad_pipe_pkg::word_t result;

    assign imm_ext = {{(`DIAD_DATA_W - 7){in.instr.i.imm[6]}}, in.instr.i.imm};

    always_comb begin
        case (in.instr.r.opcode)
            diad_isa_pkg::OP_ADD: begin
                result = in.a + in.b;
            end
            diad_isa_pkg::OP_SUB: begin
                result = in.a - in.b;
            end
            diad_isa_pkg::OP_AND: begin
                result = in.a & in.b;
            end
            diad_isa_pkg::OP_OR: begin
                result = in.a | in.b;
            end
            diad_isa_pkg::OP_XOR: begin
                result = in.a ^ in.b;
            end
            default: begin
                result = in.a + imm_ext;  // ADDI sum or LD/ST address.
            end
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out <= '0;
        end else if (advance) begin
            out <= '{valid:  in.valid,
                     pc:     in.pc,
                     instr:  in.instr,
                     result: result,
                     sdata:  in.b};
        end
    end

endmodule

// ==== verilog/diad_fetch.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_fetch (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  logic                  run,
    input  logic                  advance,
    input  logic                  stall,
    output diad_pipe_pkg::addr_t  mem_addr,
    input  diad_pipe_pkg::word_t  mem_rdata,
    output logic                  out_valid,
    output diad_pipe_pkg::addr_t  out_pc,
    output diad_isa_pkg::instr_u  out_instr
);

    diad_pipe_pkg::addr_t pc;
    diad_pipe_pkg::addr_t iss_pc;
    logic                 iss_valid;
    logic                 hold;

    assign hold = stall || !advance;

    // While held the pending word is read again so it is not lost.
    assign mem_addr = hold ? iss_pc : pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc        <= '0;
            iss_pc    <= '0;
            iss_valid <= 1'b0;
        end else if (!hold) begin
            iss_valid <= run;
            iss_pc    <= pc;
            if (run) begin
                pc <= pc + `DIAD_ADDR_W'd1;  // Upward only.
            end
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= iss_valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!hold) begin
            out_pc    <= iss_pc;
            out_instr <= mem_rdata;
        end
    end

endmodule

// ==== verilog/diad_isa_pkg.sv ====
`include "diad_config.svh"

package diad_isa_pkg;

    typedef logic [$clog2(`DIAD_NREG)-1:0] reg_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_LD   = 3'd6,
        OP_ST   = 3'd7
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_t       rd;
        reg_t       rs1;
        reg_t       rs2;
        logic [3:0] unused;
    } rfmt_t;

    typedef struct packed {
        opcode_e           opcode;
        reg_t              rd;      // Store data source for OP_ST.
        reg_t              rs1;
        logic signed [6:0] imm;
    } ifmt_t;

    typedef union packed {
        rfmt_t r;
        ifmt_t i;
    } instr_u;

endpackage

// ==== verilog/diad_mem.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_mem (
    input  logic                    iw_clk,
    input  logic [`DIAD_ADDR_W-1:0] a_addr,
    output logic [`DIAD_DATA_W-1:0] a_rdata,
    input  logic                    b_we,
    input  logic [`DIAD_ADDR_W-1:0] b_addr,
    input  logic [`DIAD_DATA_W-1:0] b_wdata,
    output logic [`DIAD_DATA_W-1:0] b_rdata
);

    localparam int DEPTH = 1 << `DIAD_ADDR_W;

    logic [`DIAD_DATA_W-1:0] ram [DEPTH];

    // Instruction port.
    always_ff @(posedge iw_clk) begin
        a_rdata <= ram[a_addr];
    end

    // Data and program load port.
    always_ff @(posedge iw_clk) begin
        if (b_we) begin
            ram[b_addr] <= b_wdata;
        end
        b_rdata <= ram[b_addr];
    end

endmodule

// ==== verilog/diad_memory.sv ====
`timescale 1ns/10ps
`include "diad_config.svh"

module diad_memory (
    input  logic                    iw_clk,
    input  logic                    iw_rst,
    input  logic                    run,
    input  diad_pipe_pkg::ex_mem_t  in,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  diad_pipe_pkg::addr_t    load_addr,
    input  diad_pipe_pkg::word_t    load_data,
    output logic                    b_we,
    output diad_pipe_pkg::addr_t    b_addr,
    output diad_pipe_pkg::word_t    b_wdata,
    input  diad_pipe_pkg::word_t    b_rdata,
    output diad_pipe_pkg::wb_t      wb,
    output logic                    retire_valid,
    input  logic                    retire_ready,
    output diad_pipe_pkg::retire_t  retire,
    output logic                    advance
);

    localparam int DCW = $clog2(`DIAD_PIPE_DEPTH + 1);
    localparam logic [DCW-1:0] DRAIN = DCW'(`DIAD_PIPE_DEPTH);

    diad_pipe_pkg::ex_mem_t s2;
    diad_pipe_pkg::word_t   value;
    logic                   s2_load;
    logic                   s2_store;
    logic                   s2_we;
    logic [DCW-1:0]         drain_cnt;

    assign advance    = !retire_valid || retire_ready;
    assign load_ready = !run && (drain_cnt == DRAIN);

    // Port B belongs to the load port while the core is stopped and empty.
    always_comb begin
        if (load_ready) begin
            b_we    = load_valid;
            b_addr  = load_addr;
            b_wdata = load_data;
        end else begin
            b_we    = advance && in.valid && (in.instr.i.opcode == diad_isa_pkg::OP_ST);
            b_addr  = advance ? in.result[`DIAD_ADDR_W-1:0] : s2.result[`DIAD_ADDR_W-1:0];
            b_wdata = in.sdata;
        end
    end

    assign s2_load  = s2.instr.i.opcode == diad_isa_pkg::OP_LD;
    assign s2_store = s2.instr.i.opcode == diad_isa_pkg::OP_ST;
    assign s2_we    = !s2_store && (s2.instr.i.rd != '0);

    assign value = s2_load ? b_rdata : (s2_store ? s2.sdata : s2.result);

    assign wb = '{en: advance && s2.valid && s2_we, rd: s2.instr.i.rd, data: value};

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            s2           <= '0;
            retire_valid <= 1'b0;
            retire       <= '0;
        end else if (advance) begin
            s2           <= in;
            retire_valid <= s2.valid;
            retire       <= '{pc: s2.pc, instr: s2.instr, we: s2_we,
                              rd: s2.instr.i.rd, value: value};
        end
    end

    // Idle cycles since the last instruction seen, saturating at the depth.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            drain_cnt <= DRAIN;
        end else if (run || in.valid || s2.valid || retire_valid) begin
            drain_cnt <= '0;
        end else if (drain_cnt != DRAIN) begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/diad_pipe_pkg.sv ====
`include "diad_config.svh"

package diad_pipe_pkg;

    typedef logic [`DIAD_ADDR_W-1:0] addr_t;
    typedef logic [`DIAD_DATA_W-1:0] word_t;

    typedef struct packed {
        logic                 valid;
        addr_t                pc;
        diad_isa_pkg::instr_u instr;
        word_t                a;
        word_t                b;       // Second operand or store data.
    } dec_ex_t;

    typedef struct packed {
        logic                 valid;
        addr_t                pc;
        diad_isa_pkg::instr_u instr;
        word_t                result;  // ALU result or data address.
        word_t                sdata;
    } ex_mem_t;

    typedef struct packed {
        logic               en;
        diad_isa_pkg::reg_t rd;
        word_t              data;
    } wb_t;

    typedef struct packed {
        addr_t              pc;
        word_t              instr;
        logic               we;
        diad_isa_pkg::reg_t rd;
        word_t              value;   // Stored data for OP_ST.
    } retire_t;

endpackage
